/* src/cpu_pkg.sv */
package cpu_pkg;

    // Data, address and register index widths.
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] imm_t;
    typedef logic [3:0]  byte_mask_t;

    localparam word_t reset_pc = 32'h0000_0000;

    // Unified program and data memory.
    localparam int mem_words      = 256;
    localparam int mem_index_bits = $clog2(mem_words);

    // Major opcodes of the supported subset.
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        class_lui,
        class_auipc,
        class_jal,
        class_jalr,
        class_branch,
        class_load,
        class_store,
        class_op_imm,
        class_op,
        class_ebreak,
        class_illegal
    } inst_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and
    } alu_funct_e;

    typedef enum logic [1:0] {
        state_run,
        state_halted,
        state_trapped
    } core_state_e;

endpackage

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t      alu_a,
    input  cpu_pkg::word_t      alu_b,
    input  cpu_pkg::alu_funct_e alu_funct,
    output cpu_pkg::word_t      alu_result,
    output logic                equal,
    output logic                less_signed
);

    logic [4:0] shamt;
    logic       less_unsigned;

    assign shamt         = alu_b[4:0];
    assign equal         = alu_a == alu_b;
    assign less_signed   = $signed(alu_a) < $signed(alu_b);
    assign less_unsigned = alu_a < alu_b;

    always_comb begin
        case (alu_funct)
            cpu_pkg::alu_add:  alu_result = alu_a + alu_b;
            cpu_pkg::alu_sub:  alu_result = alu_a - alu_b;
            cpu_pkg::alu_sll:  alu_result = alu_a << shamt;
            cpu_pkg::alu_srl:  alu_result = alu_a >> shamt;
            cpu_pkg::alu_sra:  alu_result = $signed(alu_a) >>> shamt;
            cpu_pkg::alu_slt:  alu_result = {31'b0, less_signed};
            cpu_pkg::alu_sltu: alu_result = {31'b0, less_unsigned};
            cpu_pkg::alu_xor:  alu_result = alu_a ^ alu_b;
            cpu_pkg::alu_or:   alu_result = alu_a | alu_b;
            cpu_pkg::alu_and:  alu_result = alu_a & alu_b;
            default:           alu_result = '0;
        endcase
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::word_t     src1,
    output cpu_pkg::word_t     src2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               rd_we,
    input  cpu_pkg::word_t     rd_wdata
);

    cpu_pkg::word_t regs [32];

    // x0 is never written, so it reads back as zero.
    assign src1 = regs[rs1];
    assign src2 = regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != 5'd0) begin
            regs[rd] <= rd_wdata;
        end
    end

endmodule

/* src/phys_mem.sv */
`timescale 1ns/1ps

module phys_mem (
    input  logic                clk,
    input  cpu_pkg::word_t      fetch_addr,
    output cpu_pkg::word_t      fetch_data,
    input  cpu_pkg::word_t      data_addr,
    output cpu_pkg::word_t      data_rdata,
    input  cpu_pkg::word_t      data_wdata,
    input  cpu_pkg::byte_mask_t data_mask,
    input  logic                data_we
);

    cpu_pkg::word_t mem [cpu_pkg::mem_words];

    logic [cpu_pkg::mem_index_bits-1:0] fetch_index;
    logic [cpu_pkg::mem_index_bits-1:0] data_index;

    initial begin
        $readmemh("sim/prog.hex", mem);
    end

    // Word index, byte offset dropped.
    assign fetch_index = fetch_addr[cpu_pkg::mem_index_bits+1:2];
    assign data_index  = data_addr[cpu_pkg::mem_index_bits+1:2];

    assign fetch_data = mem[fetch_index];
    assign data_rdata = mem[data_index];

    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int b = 0; b < 4; b++) begin
                if (data_mask[b]) begin
                    mem[data_index][b*8 +: 8] <= data_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  cpu_pkg::word_t       inst,
    output cpu_pkg::inst_class_e inst_class,
    output cpu_pkg::alu_funct_e  alu_funct,
    output logic [2:0]           branch_funct,
    output cpu_pkg::reg_addr_t   rd,
    output cpu_pkg::reg_addr_t   rs1,
    output cpu_pkg::reg_addr_t   rs2,
    output cpu_pkg::imm_t        imm
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    cpu_pkg::imm_t imm_i;
    cpu_pkg::imm_t imm_s;
    cpu_pkg::imm_t imm_b;
    cpu_pkg::imm_t imm_u;
    cpu_pkg::imm_t imm_j;

    assign funct3       = inst[14:12];
    assign funct7       = inst[31:25];
    assign branch_funct = funct3;
    assign rd           = inst[11:7];
    assign rs1          = inst[19:15];
    assign rs2          = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        inst_class = cpu_pkg::class_illegal;
        alu_funct  = cpu_pkg::alu_add;
        imm        = imm_i;
        case (cpu_pkg::opcode_e'(inst[6:0]))
            cpu_pkg::opc_lui: begin
                inst_class = cpu_pkg::class_lui;
                imm        = imm_u;
            end
            cpu_pkg::opc_auipc: begin
                inst_class = cpu_pkg::class_auipc;
                imm        = imm_u;
            end
            cpu_pkg::opc_jal: begin
                inst_class = cpu_pkg::class_jal;
                imm        = imm_j;
            end
            cpu_pkg::opc_jalr: begin
                if (funct3 == 3'b000) inst_class = cpu_pkg::class_jalr;
            end
            cpu_pkg::opc_branch: begin
                imm       = imm_b;
                alu_funct = cpu_pkg::alu_sub;
                // Only eq, ne, lt and ge are supported.
                if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) begin
                    inst_class = cpu_pkg::class_branch;
                end
            end
            cpu_pkg::opc_load: begin
                if (funct3 == 3'b010) inst_class = cpu_pkg::class_load;
            end
            cpu_pkg::opc_store: begin
                imm = imm_s;
                if (funct3 == 3'b000 || funct3 == 3'b010) inst_class = cpu_pkg::class_store;
            end
            cpu_pkg::opc_op_imm: begin
                inst_class = cpu_pkg::class_op_imm;
                case (funct3)
                    3'b000: alu_funct = cpu_pkg::alu_add;
                    3'b010: alu_funct = cpu_pkg::alu_slt;
                    3'b100: alu_funct = cpu_pkg::alu_xor;
                    3'b110: alu_funct = cpu_pkg::alu_or;
                    3'b111: alu_funct = cpu_pkg::alu_and;
                    3'b001: begin
                        alu_funct = cpu_pkg::alu_sll;
                        if (funct7 != 7'b0000000) inst_class = cpu_pkg::class_illegal;
                    end
                    3'b101: begin
                        if (funct7 == 7'b0000000) alu_funct = cpu_pkg::alu_srl;
                        else if (funct7 == 7'b0100000) alu_funct = cpu_pkg::alu_sra;
                        else inst_class = cpu_pkg::class_illegal;
                    end
                    default: inst_class = cpu_pkg::class_illegal;
                endcase
            end
            cpu_pkg::opc_op: begin
                inst_class = cpu_pkg::class_op;
                case (funct3)
                    3'b000: alu_funct = funct7[5] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                    3'b010: alu_funct = cpu_pkg::alu_slt;
                    3'b011: alu_funct = cpu_pkg::alu_sltu;
                    3'b100: alu_funct = cpu_pkg::alu_xor;
                    3'b110: alu_funct = cpu_pkg::alu_or;
                    3'b111: alu_funct = cpu_pkg::alu_and;
                    default: inst_class = cpu_pkg::class_illegal;
                endcase
                // Only sub may set funct7.
                if (funct7 != 7'b0000000 && !(funct3 == 3'b000 && funct7 == 7'b0100000)) begin
                    inst_class = cpu_pkg::class_illegal;
                end
            end
            cpu_pkg::opc_system: begin
                if (inst == 32'h0010_0073) inst_class = cpu_pkg::class_ebreak;
            end
            default: inst_class = cpu_pkg::class_illegal;
        endcase
    end

endmodule

/* src/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::inst_class_e inst_class,
    input  logic [2:0]           branch_funct,
    input  cpu_pkg::reg_addr_t   rd,
    input  cpu_pkg::imm_t        imm,
    input  cpu_pkg::word_t       src1,
    input  cpu_pkg::word_t       src2,
    input  cpu_pkg::word_t       alu_result,
    input  logic                 equal,
    input  logic                 less_signed,
    output cpu_pkg::word_t       alu_a,
    output cpu_pkg::word_t       alu_b,
    output cpu_pkg::word_t       pc,
    output cpu_pkg::word_t       data_addr,
    output cpu_pkg::word_t       data_wdata,
    output cpu_pkg::byte_mask_t  data_mask,
    output logic                 data_we,
    input  cpu_pkg::word_t       data_rdata,
    output logic                 rd_we,
    output cpu_pkg::word_t       rd_wdata,
    output logic                 commit_valid,
    output cpu_pkg::word_t       commit_pc,
    output cpu_pkg::reg_addr_t   commit_rd,
    output cpu_pkg::word_t       commit_data,
    output logic                 halted,
    output logic                 trapped
);

    cpu_pkg::core_state_e state;
    cpu_pkg::word_t pc_plus4;
    cpu_pkg::word_t pc_target;
    cpu_pkg::word_t next_pc;
    logic active;
    logic taken;
    logic writes_rd;
    logic store_word;

    assign active    = state == cpu_pkg::state_run;
    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;

    assign alu_a = (inst_class == cpu_pkg::class_auipc) ? pc : src1;
    assign alu_b = (inst_class == cpu_pkg::class_op || inst_class == cpu_pkg::class_branch) ?
                   src2 : imm;

    always_comb begin
        case (branch_funct)
            3'b000:  taken = equal;
            3'b001:  taken = !equal;
            3'b100:  taken = less_signed;
            3'b101:  taken = !less_signed;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (inst_class)
            cpu_pkg::class_jal:    next_pc = pc_target;
            cpu_pkg::class_jalr:   next_pc = {alu_result[31:1], 1'b0};
            cpu_pkg::class_branch: next_pc = taken ? pc_target : pc_plus4;
            default:               next_pc = pc_plus4;
        endcase
    end

    // Write-back source per instruction class.
    always_comb begin
        writes_rd = 1'b1;
        case (inst_class)
            cpu_pkg::class_lui:    rd_wdata = imm;
            cpu_pkg::class_auipc,
            cpu_pkg::class_op_imm,
            cpu_pkg::class_op:     rd_wdata = alu_result;
            cpu_pkg::class_jal,
            cpu_pkg::class_jalr:   rd_wdata = pc_plus4;
            cpu_pkg::class_load:   rd_wdata = data_rdata;
            default: begin
                writes_rd = 1'b0;
                rd_wdata  = '0;
            end
        endcase
    end

    // sb replicates the byte, the mask picks the lane.
    assign store_word = branch_funct[1];
    assign data_addr  = alu_result;
    assign data_wdata = store_word ? src2 : {4{src2[7:0]}};
    assign data_mask  = store_word ? 4'b1111 : 4'b0001 << alu_result[1:0];
    assign data_we    = active && inst_class == cpu_pkg::class_store;
    assign rd_we      = active && writes_rd;

    assign commit_valid = active && inst_class != cpu_pkg::class_illegal;
    assign commit_pc    = pc;
    assign commit_rd    = writes_rd ? rd : '0;
    assign commit_data  = rd_wdata;
    assign halted       = state == cpu_pkg::state_halted;
    assign trapped      = state == cpu_pkg::state_trapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::state_run;
            pc    <= cpu_pkg::reset_pc;
        end else if (active) begin
            case (inst_class)
                cpu_pkg::class_ebreak:  state <= cpu_pkg::state_halted;
                cpu_pkg::class_illegal: state <= cpu_pkg::state_trapped;
                default:                pc    <= next_pc;
            endcase
        end
    end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               rst,
    output logic               commit_valid,
    output cpu_pkg::word_t     commit_pc,
    output cpu_pkg::reg_addr_t commit_rd,
    output cpu_pkg::word_t     commit_data,
    output logic               halted,
    output logic               trapped
);

    cpu_pkg::word_t      pc;
    cpu_pkg::word_t      inst;
    cpu_pkg::inst_class_e inst_class;
    cpu_pkg::alu_funct_e alu_funct;
    logic [2:0]          branch_funct;
    cpu_pkg::reg_addr_t  rd;
    cpu_pkg::reg_addr_t  rs1;
    cpu_pkg::reg_addr_t  rs2;
    cpu_pkg::imm_t       imm;
    cpu_pkg::word_t      src1;
    cpu_pkg::word_t      src2;
    cpu_pkg::word_t      alu_a;
    cpu_pkg::word_t      alu_b;
    cpu_pkg::word_t      alu_result;
    logic                equal;
    logic                less_signed;
    cpu_pkg::word_t      data_addr;
    cpu_pkg::word_t      data_rdata;
    cpu_pkg::word_t      data_wdata;
    cpu_pkg::byte_mask_t data_mask;
    logic                data_we;
    logic                rd_we;
    cpu_pkg::word_t      rd_wdata;

    phys_mem u_mem (
        .clk       (clk),
        .fetch_addr(pc),
        .fetch_data(inst),
        .data_addr (data_addr),
        .data_rdata(data_rdata),
        .data_wdata(data_wdata),
        .data_mask (data_mask),
        .data_we   (data_we)
    );

    inst_decoder u_dec (
        .inst        (inst),
        .inst_class  (inst_class),
        .alu_funct   (alu_funct),
        .branch_funct(branch_funct),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .src1    (src1),
        .src2    (src2),
        .rd      (rd),
        .rd_we   (rd_we),
        .rd_wdata(rd_wdata)
    );

    alu u_alu (
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_funct  (alu_funct),
        .alu_result (alu_result),
        .equal      (equal),
        .less_signed(less_signed)
    );

    exec_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .inst_class  (inst_class),
        .branch_funct(branch_funct),
        .rd          (rd),
        .imm         (imm),
        .src1        (src1),
        .src2        (src2),
        .alu_result  (alu_result),
        .equal       (equal),
        .less_signed (less_signed),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .pc          (pc),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_mask   (data_mask),
        .data_we     (data_we),
        .data_rdata  (data_rdata),
        .rd_we       (rd_we),
        .rd_wdata    (rd_wdata),
        .commit_valid(commit_valid),
        .commit_pc   (commit_pc),
        .commit_rd   (commit_rd),
        .commit_data (commit_data),
        .halted      (halted),
        .trapped     (trapped)
    );

endmodule

/* sim/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions (
    input logic           clk,
    input logic           rst,
    input logic           commit_valid,
    input cpu_pkg::word_t commit_pc,
    input logic           halted,
    input logic           trapped
);

    // A stopped core retires nothing.
    stopped_no_commit: assert property (@(posedge clk) disable iff (rst)
        (halted || trapped) |-> !commit_valid)
        else $error("commit_valid high while the core is stopped");

    halt_trap_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(halted && trapped))
        else $error("halted and trapped are both high");

    commit_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_pc[1:0] == 2'b00)
        else $error("commit_pc is not word aligned");

    // Sticky until reset.
    halted_sticky: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted)
        else $error("halted fell without a reset");

endmodule

bind cpu_top cpu_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .commit_valid(commit_valid),
    .commit_pc   (commit_pc),
    .halted      (halted),
    .trapped     (trapped)
);

/* sim/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int quiet_cycles = 10;

    logic               clk;
    logic               rst;
    logic               commit_valid;
    cpu_pkg::word_t     commit_pc;
    cpu_pkg::reg_addr_t commit_rd;
    cpu_pkg::word_t     commit_data;
    logic               halted;
    logic               trapped;

    // Expected commits, one entry per retired instruction.
    string              exp_name[$];
    cpu_pkg::word_t     exp_pc[$];
    cpu_pkg::reg_addr_t exp_rd[$];
    cpu_pkg::word_t     exp_data[$];

    int   errors;
    int   checks;
    logic table_ready;

    cpu_top dut (
        .clk         (clk),
        .rst         (rst),
        .commit_valid(commit_valid),
        .commit_pc   (commit_pc),
        .commit_rd   (commit_rd),
        .commit_data (commit_data),
        .halted      (halted),
        .trapped     (trapped)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic add_expect(input string name, input cpu_pkg::word_t pc,
                              input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t data);
        exp_name.push_back(name);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    task automatic check_value(input string name, input cpu_pkg::word_t expected,
                               input cpu_pkg::word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    // Values follow the program in sim/prog.hex.
    task automatic build_table;
        add_expect("addi x1 5",      32'h00, 5'd1,  32'h0000_0005);
        add_expect("addi x2 -3",     32'h04, 5'd2,  32'hFFFF_FFFD);
        add_expect("add x3",         32'h08, 5'd3,  32'h0000_0002);
        add_expect("sub x4",         32'h0C, 5'd4,  32'h0000_0008);
        add_expect("slt x5",         32'h10, 5'd5,  32'h0000_0001);
        add_expect("sltu x6",        32'h14, 5'd6,  32'h0000_0000);
        add_expect("srai x7",        32'h18, 5'd7,  32'hFFFF_FFFE);
        add_expect("srli x8",        32'h1C, 5'd8,  32'h0000_000F);
        add_expect("slli x9",        32'h20, 5'd9,  32'h0000_0050);
        add_expect("xori x10",       32'h24, 5'd10, 32'h0000_000A);
        add_expect("ori x11",        32'h28, 5'd11, 32'h0000_0035);
        add_expect("andi x12",       32'h2C, 5'd12, 32'h0000_00FD);
        add_expect("lui x13",        32'h30, 5'd13, 32'h1234_5000);
        add_expect("auipc x14",      32'h34, 5'd14, 32'h0000_1034);
        add_expect("addi x15 base",  32'h38, 5'd15, 32'h0000_0100);
        add_expect("sw",             32'h3C, 5'd0,  32'h0000_0000);
        add_expect("sb",             32'h40, 5'd0,  32'h0000_0000);
        add_expect("lw x16",         32'h44, 5'd16, 32'h1234_0500);
        add_expect("beq not taken",  32'h48, 5'd0,  32'h0000_0000);
        add_expect("bne taken",      32'h4C, 5'd0,  32'h0000_0000);
        add_expect("blt taken",      32'h54, 5'd0,  32'h0000_0000);
        add_expect("bge not taken",  32'h5C, 5'd0,  32'h0000_0000);
        add_expect("jal x17",        32'h60, 5'd17, 32'h0000_0064);
        add_expect("addi x18",       32'h68, 5'd18, 32'h0000_0078);
        add_expect("jalr x19",       32'h6C, 5'd19, 32'h0000_0070);
        add_expect("addi x0",        32'h78, 5'd0,  32'h0000_000C);
        add_expect("add x20 from x0", 32'h7C, 5'd20, 32'h0000_0005);
        add_expect("ebreak",         32'h80, 5'd0,  32'h0000_0000);
    endtask

    initial begin
        int idx;
        rst         = 1'b1;
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Commit outputs are sampled mid-cycle, before the committing edge.
        idx = 0;
        while (idx < exp_pc.size()) begin
            if (trapped) begin
                report_error($sformatf("core trapped after %0d of %0d commits", idx,
                                       exp_pc.size()));
                break;
            end
            if (halted) begin
                report_error($sformatf("core halted after %0d of %0d commits", idx,
                                       exp_pc.size()));
                break;
            end
            if (commit_valid) begin
                check_value($sformatf("%s pc", exp_name[idx]), exp_pc[idx], commit_pc);
                check_value($sformatf("%s rd", exp_name[idx]), 32'(exp_rd[idx]),
                            32'(commit_rd));
                check_value($sformatf("%s data", exp_name[idx]), exp_data[idx], commit_data);
                idx++;
            end
            @(negedge clk);
        end

        // The core must stay halted and silent after ebreak.
        repeat (quiet_cycles) begin
            check_value("halted after ebreak", 32'd1, 32'(halted));
            check_value("trapped after ebreak", 32'd0, 32'(trapped));
            check_value("commit after ebreak", 32'd0, 32'(commit_valid));
            @(negedge clk);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        int limit_cycles;
        wait (table_ready === 1'b1);
        limit_cycles = exp_pc.size() + 20;
        #(limit_cycles * clk_period);
        $display("Watchdog expired after %0d cycles before the run finished.", limit_cycles);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("sim failed");
        $finish;
    end

endmodule

/* sim/prog.hex */
// One 32-bit instruction word per line, loaded from address 0.
// Words at 0x50, 0x58, 0x64, 0x70 and 0x74 are skipped by branches and jumps.
00500093
FFD00113
002081B3
40208233
001122B3
00113333
40115393
01C15413
00409493
00F0C513
0300E593
0FF17613
123456B7
00001717
10000793
00D7A023
001780A3
0007A803
00208463
00209463
FFF00F93
00114463
FFF00F93
00115463
008008EF
FFF00F93
07800913
001909E7
FFF00F93
FFF00F93
00708013
00100A33
00100073

/* sim.f */
src/cpu_pkg.sv
src/alu.sv
src/reg_file.sv
src/phys_mem.sv
src/inst_decoder.sv
src/exec_ctrl.sv
src/cpu_top.sv
sim/cpu_assertions.sv
sim/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_cpu -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
